// File: hw/soc_bus_settings.svh
`ifndef SOC_BUS_SETTINGS_SVH
`define SOC_BUS_SETTINGS_SVH

// memory map
`define RAM_BASE            64'h0000_0000_8000_0000
`define RAM_WORDS           2048                       // 32-bit words, 8 KiB
`define MTIME_ADDR          64'h0000_0000_0200_BFF8
`define MTIMECMP_ADDR       64'h0000_0000_0200_4000
`define MTIMECMP_RESET      64'h0000_0000_8000_0000

// plic window and register offsets inside it
`define PLIC_BASE           64'h0000_0000_0C00_0000
`define PLIC_SPAN           64'h0000_0000_0040_0000
`define PLIC_PENDING_OFS    64'h0000_0000_0000_1000
`define PLIC_ENABLE_OFS     64'h0000_0000_0000_2000
`define PLIC_ENABLE_STRIDE  64'h0000_0000_0000_0080    // per context
`define PLIC_THRESH_OFS     64'h0000_0000_0020_0000
`define PLIC_CTX_STRIDE     64'h0000_0000_0000_1000    // threshold and claim per context
`define PLIC_CLAIM_OFS      64'h0000_0000_0020_0004
`define PLIC_SOURCES        7                          // ids 1..7

// load/store type codes as driven by the cpu
`define LS_B                3'd0
`define LS_H                3'd1
`define LS_W                3'd2
`define LS_D                3'd3
`define LS_BU               3'd4
`define LS_HU               3'd5
`define LS_WU               3'd6

`endif

// File: hw/soc_bus_pkg.sv
`include "soc_bus_settings.svh"

package soc_bus_pkg;

    // bus side
    typedef logic [63:0] addr_t;
    typedef logic [63:0] dword_t;
    typedef logic [2:0]  ls_t;

    // ram words and plic registers are 32 bits
    typedef logic [31:0] word_t;
    typedef logic [$clog2(`RAM_WORDS)-1:0] ram_index_t;

    // plic fields
    typedef logic [2:0] prio_t;
    typedef logic [`PLIC_SOURCES-1:0] src_t;                 // bit k is id k+1
    typedef logic [$clog2(`PLIC_SOURCES + 1)-1:0] irq_id_t;   // 0 is no interrupt

    typedef enum logic [1:0] {
        IDLE,
        ISSUE,     // one strobe cycle to a target
        WAIT,      // until the target acks
        FINISH     // timer registers and unmapped space
    } seq_state_t;

    typedef enum logic {
        RAM_IDLE,
        RAM_BEAT1  // upper word of ld/sd
    } ram_state_t;

endpackage

// File: hw/bus_sequencer.sv
`timescale 1ns/1ns
`include "soc_bus_settings.svh"

module bus_sequencer (
    input  logic                CLOCK_50,
    input  logic                KEY0,
    input  soc_bus_pkg::addr_t  bus_address,
    input  soc_bus_pkg::dword_t bus_write_data,
    input  soc_bus_pkg::ls_t    bus_ls_type,
    input  logic                bus_read_enable,
    input  logic                bus_write_enable,
    output soc_bus_pkg::dword_t bus_read_data,
    output logic                bus_read_done,
    output logic                bus_write_done,
    input  soc_bus_pkg::dword_t mtime,
    output soc_bus_pkg::dword_t mtimecmp,
    output logic                ram_rd,
    output logic                ram_wr,
    input  logic                ram_ack,
    input  soc_bus_pkg::dword_t ram_rdata,
    output logic                plic_rd,
    output logic                plic_wr,
    input  logic                plic_ack,
    input  soc_bus_pkg::word_t  plic_rdata,
    output soc_bus_pkg::addr_t  req_addr,
    output soc_bus_pkg::ls_t    req_type,
    output soc_bus_pkg::dword_t req_wdata
);
    import soc_bus_pkg::*;

    seq_state_t state;
    logic       start;         // strobe accepted this cycle
    logic       is_write;
    logic       hit_ram;
    logic       hit_plic;
    logic       hit_mtime;
    logic       hit_mtimecmp;
    logic       sel_ram;
    logic       sel_plic;
    logic       sel_mtime;
    logic       sel_mtimecmp;

    assign start = (state == IDLE) && (bus_read_enable || bus_write_enable);

    // decode of the live address, only kept on the strobe edge
    assign hit_ram      = (bus_address >= `RAM_BASE) &&
                          (bus_address < `RAM_BASE + 4 * `RAM_WORDS);
    assign hit_plic     = (bus_address >= `PLIC_BASE) &&
                          (bus_address < `PLIC_BASE + `PLIC_SPAN);
    assign hit_mtime    = (bus_address == `MTIME_ADDR);
    assign hit_mtimecmp = (bus_address == `MTIMECMP_ADDR);

    // single-cycle target strobes
    assign ram_rd  = (state == ISSUE) && sel_ram && !is_write;
    assign ram_wr  = (state == ISSUE) && sel_ram && is_write;
    assign plic_rd = (state == ISSUE) && sel_plic && !is_write;
    assign plic_wr = (state == ISSUE) && sel_plic && is_write;

    always_ff @(posedge CLOCK_50 or negedge KEY0) begin
        if (!KEY0) begin
            state          <= IDLE;
            bus_read_done  <= 1'b1;
            bus_write_done <= 1'b1;
            is_write       <= 1'b0;
            sel_ram        <= 1'b0;
            sel_plic       <= 1'b0;
            sel_mtime      <= 1'b0;
            sel_mtimecmp   <= 1'b0;
            mtimecmp       <= `MTIMECMP_RESET;
        end else begin
            case (state)
                IDLE: begin
                    if (start) begin
                        if (bus_read_enable)
                            bus_read_done <= 1'b0;
                        else
                            bus_write_done <= 1'b0;
                        is_write     <= !bus_read_enable;
                        sel_ram      <= hit_ram;
                        sel_plic     <= hit_plic;
                        sel_mtime    <= hit_mtime;
                        sel_mtimecmp <= hit_mtimecmp;
                        state        <= ISSUE;
                    end
                end
                ISSUE: begin
                    // timer registers and holes are answered locally
                    state <= (sel_ram || sel_plic) ? WAIT : FINISH;
                end
                WAIT: begin
                    if (ram_ack || plic_ack) begin
                        if (is_write)
                            bus_write_done <= 1'b1;
                        else
                            bus_read_done <= 1'b1;
                        state <= IDLE;
                    end
                end
                FINISH: begin
                    if (is_write && sel_mtimecmp)
                        mtimecmp <= req_wdata;
                    if (is_write)
                        bus_write_done <= 1'b1;
                    else
                        bus_read_done <= 1'b1;
                    state <= IDLE;
                end
                default: state <= IDLE;
            endcase
        end
    end

    // request latch and read data return
    always_ff @(posedge CLOCK_50) begin
        if (start) begin
            req_addr  <= bus_address;
            req_type  <= bus_ls_type;
            req_wdata <= bus_write_data;
        end
        if (!is_write) begin
            if (state == WAIT && ram_ack)
                bus_read_data <= ram_rdata;
            else if (state == WAIT && plic_ack)
                bus_read_data <= {32'd0, plic_rdata};      // plic words zero-extend
            else if (state == FINISH)
                bus_read_data <= sel_mtime    ? mtime :
                                 sel_mtimecmp ? mtimecmp : '0;   // unmapped reads 0
        end
    end

endmodule

// File: hw/ram_port.sv
`timescale 1ns/1ns
`include "soc_bus_settings.svh"

module ram_port (
    input  logic                CLOCK_50,
    input  logic                KEY0,
    input  logic                ram_rd,
    input  logic                ram_wr,
    input  soc_bus_pkg::addr_t  req_addr,
    input  soc_bus_pkg::ls_t    req_type,
    input  soc_bus_pkg::dword_t req_wdata,
    output logic                ram_ack,
    output soc_bus_pkg::dword_t ram_rdata
);
    import soc_bus_pkg::*;

    word_t      mem [0:`RAM_WORDS-1];
    ram_state_t state;
    logic       beat_wr;       // second beat is the upper half of an sd
    logic       is_double;
    addr_t      ofs;
    ram_index_t idx;
    ram_index_t idx_hi;
    word_t      lo_word;       // lower half of an ld

    assign ofs       = req_addr - `RAM_BASE;
    assign idx       = ram_index_t'(ofs >> 2);
    assign idx_hi    = idx + ram_index_t'(1);
    assign is_double = (req_type == `LS_D);

    // align the addressed lane to bit 0, then extend by type
    function automatic dword_t load_extend(word_t w, logic [1:0] lane, ls_t t);
        word_t s;
        s = w >> (8 * lane);
        case (t)
            `LS_B:   return {{56{s[7]}}, s[7:0]};
            `LS_H:   return {{48{s[15]}}, s[15:0]};
            `LS_BU:  return {56'd0, s[7:0]};
            `LS_HU:  return {48'd0, s[15:0]};
            `LS_WU:  return {32'd0, s};
            default: return {{32{s[31]}}, s};          // lw
        endcase
    endfunction

    function automatic word_t store_merge(word_t old, dword_t wd, logic [1:0] lane, ls_t t);
        word_t w;
        w = old;
        case (t)
            `LS_B: w[8 * lane +: 8] = wd[7:0];
            `LS_H: begin
                // halves only at 0 and 2, odd offsets leave the word alone
                if (lane == 2'd0)
                    w[15:0] = wd[15:0];
                else if (lane == 2'd2)
                    w[31:16] = wd[15:0];
            end
            default: w = wd[31:0];                     // sw, low half of sd
        endcase
        return w;
    endfunction

    always_ff @(posedge CLOCK_50 or negedge KEY0) begin
        if (!KEY0) begin
            state   <= RAM_IDLE;
            ram_ack <= 1'b0;
            beat_wr <= 1'b0;
        end else begin
            ram_ack <= 1'b0;
            case (state)
                RAM_IDLE: begin
                    if ((ram_rd || ram_wr) && is_double) begin
                        beat_wr <= ram_wr;
                        state   <= RAM_BEAT1;
                    end else if (ram_rd || ram_wr) begin
                        ram_ack <= 1'b1;
                    end
                end
                RAM_BEAT1: begin
                    ram_ack <= 1'b1;
                    state   <= RAM_IDLE;
                end
                default: state <= RAM_IDLE;
            endcase
        end
    end

    always_ff @(posedge CLOCK_50) begin
        if (state == RAM_IDLE) begin
            if (ram_wr)
                mem[idx] <= store_merge(mem[idx], req_wdata, ofs[1:0], req_type);
            if (ram_rd) begin
                lo_word   <= mem[idx];
                ram_rdata <= load_extend(mem[idx], ofs[1:0], req_type);
            end
        end else if (beat_wr) begin
            mem[idx_hi] <= req_wdata[63:32];
        end else begin
            ram_rdata <= {mem[idx_hi], lo_word};       // low word first
        end
    end

endmodule

// File: hw/plic.sv
`timescale 1ns/1ns
`include "soc_bus_settings.svh"

module plic (
    input  logic                CLOCK_50,
    input  logic                KEY0,
    input  logic                plic_rd,
    input  logic                plic_wr,
    input  soc_bus_pkg::addr_t  req_addr,
    input  soc_bus_pkg::dword_t req_wdata,
    output logic                plic_ack,
    output soc_bus_pkg::word_t  plic_rdata,
    input  soc_bus_pkg::src_t   irq_lines,
    output logic                meip,
    output logic                seip
);
    import soc_bus_pkg::*;

    localparam int CTX = 2;    // hart 0 M-mode, hart 0 S-mode

    prio_t [`PLIC_SOURCES-1:0] prio;    // entry k is id k+1
    src_t    pending;
    src_t    irq_d;
    src_t    rise;
    src_t    clear;
    src_t    enable [CTX];
    prio_t   thresh [CTX];
    irq_id_t claim [CTX];
    addr_t   ofs;
    irq_id_t prio_id;
    logic    prio_hit;
    word_t   rd_mux;

    // highest priority strictly above threshold, lowest id on a tie
    function automatic irq_id_t best_id(src_t pend, src_t en, prio_t thr,
                                        prio_t [`PLIC_SOURCES-1:0] pr);
        irq_id_t id;
        prio_t   top;
        id  = '0;
        top = thr;
        for (int k = 0; k < `PLIC_SOURCES; k++) begin
            if (pend[k] && en[k] && pr[k] > top) begin
                id  = irq_id_t'(k + 1);
                top = pr[k];
            end
        end
        return id;
    endfunction

    assign ofs      = req_addr - `PLIC_BASE;
    assign prio_id  = irq_id_t'(ofs >> 2);
    assign prio_hit = (ofs >= 4) && (ofs < 4 * (`PLIC_SOURCES + 1)) && (ofs[1:0] == 2'd0);
    assign rise     = irq_lines & ~irq_d;

    always_comb begin
        for (int c = 0; c < CTX; c++) begin
            claim[c] = best_id(pending, enable[c], thresh[c], prio);
        end
    end

    // register read mux, a claim read also names the pending bit to drop
    always_comb begin
        rd_mux = '0;
        clear  = '0;
        if (prio_hit)
            rd_mux = word_t'(prio[prio_id - 1'b1]);
        if (ofs == `PLIC_PENDING_OFS)
            rd_mux = word_t'({pending, 1'b0});         // bit i is id i
        for (int c = 0; c < CTX; c++) begin
            if (ofs == `PLIC_ENABLE_OFS + c * `PLIC_ENABLE_STRIDE)
                rd_mux = word_t'({enable[c], 1'b0});
            if (ofs == `PLIC_THRESH_OFS + c * `PLIC_CTX_STRIDE)
                rd_mux = word_t'(thresh[c]);
            if (ofs == `PLIC_CLAIM_OFS + c * `PLIC_CTX_STRIDE) begin
                rd_mux = word_t'(claim[c]);
                if (claim[c] != '0)
                    clear[claim[c] - 1'b1] = 1'b1;
            end
        end
    end

    always_ff @(posedge CLOCK_50 or negedge KEY0) begin
        if (!KEY0) begin
            prio     <= '0;
            pending  <= '0;
            irq_d    <= '0;
            plic_ack <= 1'b0;
            meip     <= 1'b0;
            seip     <= 1'b0;
            for (int c = 0; c < CTX; c++) begin
                enable[c] <= '0;
                thresh[c] <= '0;
            end
        end else begin
            irq_d    <= irq_lines;
            plic_ack <= plic_rd || plic_wr;
            meip     <= (claim[0] != '0);
            seip     <= (claim[1] != '0);
            if (plic_rd)
                pending <= (pending & ~clear) | rise;  // new edge wins over a claim
            else
                pending <= pending | rise;
            if (plic_wr) begin
                if (prio_hit)
                    prio[prio_id - 1'b1] <= prio_t'(req_wdata);
                for (int c = 0; c < CTX; c++) begin
                    if (ofs == `PLIC_ENABLE_OFS + c * `PLIC_ENABLE_STRIDE)
                        enable[c] <= req_wdata[`PLIC_SOURCES:1];
                    if (ofs == `PLIC_THRESH_OFS + c * `PLIC_CTX_STRIDE)
                        thresh[c] <= prio_t'(req_wdata);
                end
            end
        end
    end

    always_ff @(posedge CLOCK_50) begin
        if (plic_rd)
            plic_rdata <= rd_mux;
    end

endmodule

// File: hw/soc_bus_top.sv
`timescale 1ns/1ns

module soc_bus_top (
    input  logic                CLOCK_50,
    input  logic                KEY0,
    input  soc_bus_pkg::addr_t  bus_address,
    input  soc_bus_pkg::dword_t bus_write_data,
    input  soc_bus_pkg::ls_t    bus_ls_type,
    input  logic                bus_read_enable,
    input  logic                bus_write_enable,
    output soc_bus_pkg::dword_t bus_read_data,
    output logic                bus_read_done,
    output logic                bus_write_done,
    input  soc_bus_pkg::dword_t mtime,
    output soc_bus_pkg::dword_t mtimecmp,
    input  soc_bus_pkg::src_t   irq_lines,
    output logic                meip,
    output logic                seip
);
    import soc_bus_pkg::*;

    logic   ram_rd;
    logic   ram_wr;
    logic   ram_ack;
    dword_t ram_rdata;
    logic   plic_rd;
    logic   plic_wr;
    logic   plic_ack;
    word_t  plic_rdata;
    addr_t  req_addr;    // held by the sequencer for the whole access
    ls_t    req_type;
    dword_t req_wdata;

    bus_sequencer i_bus_sequencer (.*);

    ram_port i_ram_port (
        .CLOCK_50  (CLOCK_50),
        .KEY0      (KEY0),
        .ram_rd    (ram_rd),
        .ram_wr    (ram_wr),
        .req_addr  (req_addr),
        .req_type  (req_type),
        .req_wdata (req_wdata),
        .ram_ack   (ram_ack),
        .ram_rdata (ram_rdata)
    );

    plic i_plic (.*);

endmodule

// File: test/soc_bus_chk.sv
`timescale 1ns/1ns

module soc_bus_chk (
    input logic CLOCK_50,
    input logic KEY0,
    input logic bus_read_enable,
    input logic bus_write_enable,
    input logic bus_read_done,
    input logic bus_write_done,
    input logic ram_rd,
    input logic ram_wr,
    input logic plic_rd,
    input logic plic_wr
);
    int unsigned fail_count = 0;    // polled from the testbench top

    // done drops on the edge that samples the strobe
    a_read_drop: assert property (@(posedge CLOCK_50) disable iff (!KEY0)
        bus_read_enable |=> !bus_read_done)
        else begin
            $error("read done still high after a read strobe");
            fail_count++;
        end

    a_write_drop: assert property (@(posedge CLOCK_50) disable iff (!KEY0)
        bus_write_enable |=> !bus_write_done)
        else begin
            $error("write done still high after a write strobe");
            fail_count++;
        end

    // no access may take longer than 8 cycles
    a_read_back: assert property (@(posedge CLOCK_50) disable iff (!KEY0)
        $fell(bus_read_done) |-> ##[1:8] bus_read_done)
        else begin
            $error("read done did not rise within 8 cycles");
            fail_count++;
        end

    a_write_back: assert property (@(posedge CLOCK_50) disable iff (!KEY0)
        $fell(bus_write_done) |-> ##[1:8] bus_write_done)
        else begin
            $error("write done did not rise within 8 cycles");
            fail_count++;
        end

    a_one_target: assert property (@(posedge CLOCK_50) disable iff (!KEY0)
        $onehot0({ram_rd, ram_wr, plic_rd, plic_wr}))
        else begin
            $error("more than one target strobe in the same cycle");
            fail_count++;
        end

endmodule

bind bus_sequencer soc_bus_chk i_soc_bus_chk (
    .CLOCK_50         (CLOCK_50),
    .KEY0             (KEY0),
    .bus_read_enable  (bus_read_enable),
    .bus_write_enable (bus_write_enable),
    .bus_read_done    (bus_read_done),
    .bus_write_done   (bus_write_done),
    .ram_rd           (ram_rd),
    .ram_wr           (ram_wr),
    .plic_rd          (plic_rd),
    .plic_wr          (plic_wr)
);

// File: test/soc_bus_tb.sv
`timescale 1ns/1ns
`include "soc_bus_settings.svh"

module soc_bus_tb;
    import soc_bus_pkg::*;

    localparam int RAM_OPS   = 300;
    localparam int IRQ_RUNS  = 8;
    // fill, random ram traffic, irq rounds, timers, final read-back
    localparam int TOTAL_OPS = 64 + RAM_OPS + IRQ_RUNS * 50 + 100;
    localparam addr_t HOLE   = 64'h0000_0000_4000_0000;

    logic   CLOCK_50 = 1'b0;
    logic   KEY0;
    addr_t  bus_address;
    dword_t bus_write_data;
    ls_t    bus_ls_type;
    logic   bus_read_enable;
    logic   bus_write_enable;
    dword_t bus_read_data;
    logic   bus_read_done;
    logic   bus_write_done;
    dword_t mtime;
    dword_t mtimecmp;
    src_t   irq_lines;
    logic   meip;
    logic   seip;

    logic [7:0] ram_m [0:255];              // byte model of the first 64 words
    prio_t      prio_m [1:`PLIC_SOURCES];
    src_t       en_m [2];
    prio_t      thr_m [2];
    src_t       pend_m;

    soc_bus_top i_soc_bus_top (.*);

    initial begin
        forever #10 CLOCK_50 = ~CLOCK_50;
    end

    initial begin
        #(TOTAL_OPS * 8 * 20 * 4);
        $display("timeout, the bus stopped responding");
        stop_failed();
    end

    always @(negedge CLOCK_50) begin
        if (i_soc_bus_top.i_bus_sequencer.i_soc_bus_chk.fail_count != 0) begin
            $display("bus protocol assertion failed");
            stop_failed();
        end
    end

    task automatic stop_failed();
        $display("STATUS: FAIL");
        $fatal(1, "run stopped at the first error");
    endtask

    task automatic check_value(input string name, input dword_t got, input dword_t exp);
        assert (got === exp)
        else begin
            $display("ERROR %s: got 0x%h, expected 0x%h", name, got, exp);
            stop_failed();
        end
    endtask

    task automatic bus_write(input addr_t a, input dword_t d, input ls_t t);
        @(negedge CLOCK_50);
        bus_address      = a;
        bus_write_data   = d;
        bus_ls_type      = t;
        bus_write_enable = 1'b1;
        @(negedge CLOCK_50);
        bus_write_enable = 1'b0;
        while (!bus_write_done)
            @(negedge CLOCK_50);
    endtask

    task automatic read_expect(input addr_t a, input ls_t t, input dword_t exp);
        @(negedge CLOCK_50);
        bus_address     = a;
        bus_ls_type     = t;
        bus_read_enable = 1'b1;
        @(negedge CLOCK_50);
        bus_read_enable = 1'b0;
        while (!bus_read_done)
            @(negedge CLOCK_50);
        assert (bus_read_data === exp)
        else begin
            $display("ERROR bus_read_data @0x%h: got 0x%h, expected 0x%h",
                     a, bus_read_data, exp);
            stop_failed();
        end
    endtask

    function automatic word_t fill_word(input addr_t a);
        return a[31:0] ^ {a[15:0], a[31:16]} ^ a[63:32] ^ 32'h3c5a_96e1;
    endfunction

    task automatic ram_store(input int unsigned a, input dword_t d, input ls_t t);
        case (t)
            `LS_B: ram_m[a] = d[7:0];
            `LS_H: if (a % 2 == 0) {ram_m[a + 1], ram_m[a]} = d[15:0];  // odd halves dropped
            `LS_W: for (int k = 0; k < 4; k++) ram_m[(a & ~32'h3) + k] = d[8 * k +: 8];
            default: for (int k = 0; k < 8; k++) ram_m[(a & ~32'h7) + k] = d[8 * k +: 8];
        endcase
        bus_write(`RAM_BASE + a, d, t);
    endtask

    function automatic dword_t ram_expect(input int unsigned a, input ls_t t);
        int unsigned base;
        word_t       w;
        dword_t      d;
        base = a & ~32'h3;
        w = {ram_m[base + 3], ram_m[base + 2], ram_m[base + 1], ram_m[base]};
        w = w >> (8 * (a % 4));             // lane moves down to bit 0
        for (int k = 0; k < 8; k++)
            d[8 * k +: 8] = ram_m[(a & ~32'h7) + k];
        case (t)
            `LS_B:  return {{56{w[7]}}, w[7:0]};
            `LS_H:  return {{48{w[15]}}, w[15:0]};
            `LS_BU: return {56'd0, w[7:0]};
            `LS_HU: return {48'd0, w[15:0]};
            `LS_WU: return {32'd0, w};
            `LS_D:  return d;
            default: return {{32{w[31]}}, w};
        endcase
    endfunction

    task automatic random_ram_op();
        int unsigned a;
        ls_t         t;
        logic        store;
        a     = $urandom_range(0, 255);
        store = $urandom_range(0, 1);
        t     = store ? ls_t'($urandom_range(0, 3)) : ls_t'($urandom_range(0, 6));
        if (t == `LS_D)
            a = a & ~32'h7;
        else if (t == `LS_W || t == `LS_WU)
            a = a & ~32'h3;
        if (store)
            ram_store(a, {$urandom, $urandom}, t);
        else
            read_expect(`RAM_BASE + a, t, ram_expect(a, t));
    endtask

    // best pending and enabled source strictly above threshold, low id on a tie
    function automatic irq_id_t model_claim(input int c);
        irq_id_t id;
        prio_t   top;
        id  = '0;
        top = thr_m[c];
        for (int k = 1; k <= `PLIC_SOURCES; k++) begin
            if (pend_m[k - 1] && en_m[c][k - 1] && prio_m[k] > top) begin
                id  = irq_id_t'(k);
                top = prio_m[k];
            end
        end
        return id;
    endfunction

    task automatic check_plic();
        repeat (2) @(negedge CLOCK_50);
        check_value("meip", meip, model_claim(0) != 0);
        check_value("seip", seip, model_claim(1) != 0);
        read_expect(`PLIC_BASE + `PLIC_PENDING_OFS, `LS_WU, {pend_m, 1'b0});
    endtask

    task automatic irq_round();
        irq_id_t id;
        for (int k = 1; k <= `PLIC_SOURCES; k++) begin
            prio_m[k] = prio_t'($urandom_range(0, 7));
            bus_write(`PLIC_BASE + 4 * k, prio_m[k], `LS_W);
        end
        for (int c = 0; c < 2; c++) begin
            en_m[c]  = src_t'($urandom);
            thr_m[c] = prio_t'($urandom_range(0, 3));   // low, so most rounds claim
            bus_write(`PLIC_BASE + `PLIC_ENABLE_OFS + c * `PLIC_ENABLE_STRIDE,
                      {en_m[c], 1'b0}, `LS_W);
            bus_write(`PLIC_BASE + `PLIC_THRESH_OFS + c * `PLIC_CTX_STRIDE, thr_m[c], `LS_W);
        end
        check_plic();
        @(negedge CLOCK_50);
        irq_lines = src_t'($urandom);
        pend_m    = pend_m | irq_lines;     // lines were all low
        check_plic();
        for (int c = 0; c < 2; c++) begin
            while (model_claim(c) != 0) begin
                id = model_claim(c);
                read_expect(`PLIC_BASE + `PLIC_CLAIM_OFS + c * `PLIC_CTX_STRIDE, `LS_WU, id);
                pend_m[id - 1] = 1'b0;
                check_plic();
            end
            read_expect(`PLIC_BASE + `PLIC_CLAIM_OFS + c * `PLIC_CTX_STRIDE, `LS_WU, '0);
        end
        check_value("meip", meip, 1'b0);
        check_value("seip", seip, 1'b0);
        irq_lines = '0;
    endtask

    initial begin
        dword_t d;
        void'($urandom(32'h2ddc_d98f));
        KEY0             = 1'b0;
        bus_address      = '0;
        bus_write_data   = '0;
        bus_ls_type      = `LS_W;
        bus_read_enable  = 1'b0;
        bus_write_enable = 1'b0;
        mtime            = '0;
        irq_lines        = '0;
        pend_m           = '0;
        repeat (5) @(negedge CLOCK_50);
        KEY0 = 1'b1;
        @(negedge CLOCK_50);

        check_value("bus_read_done", bus_read_done, 1'b1);
        check_value("bus_write_done", bus_write_done, 1'b1);
        check_value("meip", meip, 1'b0);
        check_value("seip", seip, 1'b0);
        check_value("mtimecmp", mtimecmp, `MTIMECMP_RESET);
        read_expect(`MTIMECMP_ADDR, `LS_D, `MTIMECMP_RESET);

        d = {$urandom, $urandom};
        bus_write(`MTIMECMP_ADDR, d, `LS_D);
        read_expect(`MTIMECMP_ADDR, `LS_D, d);
        check_value("mtimecmp", mtimecmp, d);
        mtime = {$urandom, $urandom};       // still on a falling edge here
        read_expect(`MTIME_ADDR, `LS_D, mtime);

        for (int w = 0; w < 64; w++)
            ram_store(4 * w, fill_word(`RAM_BASE + 4 * w), `LS_W);
        repeat (RAM_OPS) random_ram_op();

        repeat (IRQ_RUNS) irq_round();

        // unmapped space below ram, just past ram and next to the timers
        read_expect(`MTIMECMP_ADDR, `LS_D, d);     // nonzero data ahead of the hole read
        read_expect(HOLE, `LS_D, '0);
        bus_write(HOLE, {$urandom, $urandom}, `LS_D);
        bus_write(`RAM_BASE + 4 * `RAM_WORDS, $urandom, `LS_W);
        bus_write(64'h0000_0000_0200_0000, {$urandom, $urandom}, `LS_D);
        for (int w = 0; w < 64; w++)
            read_expect(`RAM_BASE + 4 * w, `LS_WU, ram_expect(4 * w, `LS_WU));
        for (int k = 1; k <= `PLIC_SOURCES; k++)
            read_expect(`PLIC_BASE + 4 * k, `LS_WU, prio_m[k]);
        for (int c = 0; c < 2; c++) begin
            read_expect(`PLIC_BASE + `PLIC_ENABLE_OFS + c * `PLIC_ENABLE_STRIDE,
                        `LS_WU, {en_m[c], 1'b0});
            read_expect(`PLIC_BASE + `PLIC_THRESH_OFS + c * `PLIC_CTX_STRIDE, `LS_WU, thr_m[c]);
        end
        read_expect(`PLIC_BASE + `PLIC_PENDING_OFS, `LS_WU, {pend_m, 1'b0});
        read_expect(`MTIMECMP_ADDR, `LS_D, d);

        repeat (2) @(negedge CLOCK_50);
        if (i_soc_bus_top.i_bus_sequencer.i_soc_bus_chk.fail_count == 0) begin
            $display("STATUS: PASS");
            $finish;
        end else begin
            $display("bus protocol assertion failed");
            stop_failed();
        end
    end

endmodule

// File: project.f
+incdir+hw
hw/soc_bus_pkg.sv
hw/bus_sequencer.sv
hw/ram_port.sv
hw/plic.sv
hw/soc_bus_top.sv
test/soc_bus_chk.sv
test/soc_bus_tb.sv
